// File: hdl/selftest_pkg.sv
// Self-test widths, UART and flash timing constants, flash command, controller states
package selftest_pkg;

    typedef logic [7:0]  byte_t;        // UART, SPI and compare data
    typedef logic [23:0] flash_addr_t;  // SPI flash byte address

    // UART
    localparam int CLKS_PER_BIT = 8;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;  // Rx sample point
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BITS   = 10;                // Start, 8 data, stop

    // Start-up delay, overflow of a 6-bit counter
    localparam int STARTUP_CYCLES = 64;
    localparam int STARTUP_W      = $clog2(STARTUP_CYCLES);

    // Test run
    localparam int TEST_BYTES   = 8;
    localparam int BYTE_CNT_W   = $clog2(TEST_BYTES);
    localparam int ECHO_TIMEOUT = 4 * FRAME_BITS * CLKS_PER_BIT;  // Four frames
    localparam int ECHO_W       = $clog2(ECHO_TIMEOUT);

    // SPI flash
    localparam byte_t       FLASH_CMD_READ = 8'h03;  // Plain read, no dummy
    localparam flash_addr_t TEST_BASE_ADDR = 24'h000000;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        SEND,
        WAIT_ECHO,
        DONE
    } ctrl_state_t;

endpackage

// File: hdl/serial_if.sv
// Byte-level UART transmit and receive bundle with ctrl, tx and rx modports
`timescale 1ns/100ps

interface serial_if
    import selftest_pkg::*;
();
    byte_t tx_data;   // Byte to send
    logic  tx_start;  // One-cycle pulse
    logic  tx_busy;   // High for the whole frame
    byte_t rx_data;   // Last received byte
    logic  rx_valid;  // One-cycle pulse, mid stop bit

    modport ctrl (
        output tx_data, tx_start,
        input  tx_busy, rx_data, rx_valid
    );

    modport tx (input tx_data, tx_start, output tx_busy);

    modport rx (output rx_data, rx_valid);

endinterface

// File: hdl/flash_read_if.sv
// Byte request link between the self-test controller and the SPI flash reader
`timescale 1ns/100ps

interface flash_read_if
    import selftest_pkg::*;
();
    logic  start;     // Pulse, opens a read transaction
    logic  stop;      // Pulse, closes it
    logic  byte_req;  // Pulse, next byte please
    byte_t rd_data;
    logic  rd_valid;  // One-cycle pulse
    logic  ready;     // Command and address sent

    modport ctrl (
        output start, stop, byte_req,
        input  rd_data, rd_valid, ready
    );

    modport reader (
        input  start, stop, byte_req,
        output rd_data, rd_valid, ready
    );

endinterface

// File: hdl/power_on_delay.sv
// Power-on delay counter raising the run level after the start-up time
`timescale 1ns/100ps

module power_on_delay
    import selftest_pkg::*;
(
    input  logic clk,
    input  logic i_rst,
    output logic o_run
);

    logic [STARTUP_W-1:0] waiting;  // Start-up count

    // Flash needs time to wake before the first command
    always_ff @(posedge clk) begin
        if (i_rst) begin
            waiting <= '0;
            o_run   <= 1'b0;
        end else if (!o_run) begin
            {o_run, waiting} <= {1'b0, waiting} + 1'b1;  // Carry out sets run
        end
    end

endmodule

// File: hdl/uart_tx.sv
// 8N1 UART transmitter
`timescale 1ns/100ps

module uart_tx
    import selftest_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,
    output logic     o_tx,
    serial_if.tx     ser
);

    logic [FRAME_BITS-1:0] frame;     // Stop, data, start; LSB on the line
    logic [BAUD_W-1:0]     baud_cnt;
    logic [3:0]            bit_cnt;   // Bit currently on the line
    logic                  busy;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            frame    <= '1;  // Line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
        end else if (!busy) begin
            if (ser.tx_start) begin
                frame    <= {1'b1, ser.tx_data, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
                busy     <= 1'b1;
            end
        end else if (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[FRAME_BITS-1:1]};  // Refill with idle
            if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                busy <= 1'b0;  // End of stop bit
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign o_tx        = frame[0];
    assign ser.tx_busy = busy;

    // Controller must hold off while a frame is on the line
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (i_rst) ser.tx_start |-> !busy
    );

endmodule

// File: hdl/uart_rx.sv
// 8N1 UART receiver with two-flop synchronizer and mid-bit sampling
`timescale 1ns/100ps

module uart_rx
    import selftest_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_rx,
    serial_if.rx     ser
);

    logic [2:0]        sync;      // Two sync stages, then one for edge detect
    logic              line;      // Synchronized line
    logic              fall;      // Start edge
    logic              busy;
    logic [BAUD_W-1:0] baud_cnt;  // Down count to next sample
    logic [3:0]        bit_cnt;
    byte_t             shreg;
    logic              valid;

    assign line = sync[1];
    assign fall = sync[2] && !sync[1];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            sync     <= '1;  // No false edge out of reset
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid    <= 1'b0;
        end else begin
            sync  <= {sync[1:0], i_rx};
            valid <= 1'b0;
            if (!busy) begin
                if (fall) begin
                    busy     <= 1'b1;
                    baud_cnt <= BAUD_W'(HALF_BIT - 1);  // Middle of start bit
                    bit_cnt  <= '0;
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= BAUD_W'(CLKS_PER_BIT - 1);
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0) begin
                    if (line) begin
                        busy <= 1'b0;  // Glitch, not a start bit
                    end
                end else if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    busy  <= 1'b0;
                    valid <= line;  // Bad stop bit drops the frame
                end else begin
                    shreg <= {line, shreg[7:1]};  // LSB first
                end
            end
        end
    end

    assign ser.rx_data  = shreg;
    assign ser.rx_valid = valid;

endmodule

// File: hdl/spi_flash_reader.sv
// SPI mode-0 flash reader sending the read command, then one byte per request
`timescale 1ns/100ps

module spi_flash_reader
    import selftest_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst,
    output logic          o_cs,
    output logic          o_sclk,
    output logic          o_copi,
    input  logic          i_cipo,
    flash_read_if.reader  fr
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_CMD,    // Command and address out
        RD_READY,  // Waiting for a byte request
        RD_BYTE    // Clocking in one byte
    } rd_state_t;

    rd_state_t   state;
    logic [31:0] cmd_sr;   // Command then address, MSB first
    byte_t       rx_sr;
    logic [4:0]  bit_cnt;  // Falling edges so far
    logic        valid;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= RD_IDLE;
            o_cs    <= 1'b1;
            o_sclk  <= 1'b0;
            cmd_sr  <= '0;  // copi idles low
            bit_cnt <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (fr.stop) begin
                state  <= RD_IDLE;
                o_cs   <= 1'b1;
                o_sclk <= 1'b0;
                cmd_sr <= '0;
            end else begin
                case (state)
                    RD_IDLE: begin
                        if (fr.start) begin
                            o_cs    <= 1'b0;
                            cmd_sr  <= {FLASH_CMD_READ, TEST_BASE_ADDR};
                            bit_cnt <= '0;
                            state   <= RD_CMD;
                        end
                    end
                    RD_CMD: begin
                        o_sclk <= !o_sclk;  // clk/2
                        if (o_sclk) begin   // Falling edge, next bit on copi
                            cmd_sr  <= {cmd_sr[30:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 5'd31) begin
                                state <= RD_READY;
                            end
                        end
                    end
                    RD_READY: begin
                        if (fr.byte_req) begin
                            bit_cnt <= '0;
                            state   <= RD_BYTE;
                        end
                    end
                    RD_BYTE: begin
                        o_sclk <= !o_sclk;
                        if (!o_sclk) begin
                            rx_sr <= {rx_sr[6:0], i_cipo};  // Sample on rising edge
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 5'd7) begin
                                valid <= 1'b1;  // 16 clk after request
                                state <= RD_READY;
                            end
                        end
                    end
                    default: state <= RD_IDLE;
                endcase
            end
        end
    end

    assign o_copi      = cmd_sr[31];
    assign fr.rd_data  = rx_sr;
    assign fr.rd_valid = valid;
    assign fr.ready    = (state == RD_READY) || (state == RD_BYTE);

    // Flash sees no clock edges while deselected
    a_sclk_only_selected: assert property (
        @(posedge clk) disable iff (i_rst) $changed(o_sclk) |-> !o_cs
    );

endmodule

// File: hdl/selftest_ctrl.sv
// Self-test sequencer moving flash bytes to the UART, checking echoes, driving the LEDs
`timescale 1ns/100ps

module selftest_ctrl
    import selftest_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_run,
    serial_if.ctrl      ser,
    flash_read_if.ctrl  fr,
    output logic        o_led_r,
    output logic        o_led_g,
    output logic        o_led_b
);

    ctrl_state_t           state;
    byte_t                 tx_byte;   // Byte in flight, compared with the echo
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic [ECHO_W-1:0]     timer;     // Echo wait
    logic                  passed;    // Cleared on any bad or missing echo
    logic                  req_sent;  // Byte outstanding at the reader
    logic                  tx_start;
    logic                  byte_req;
    logic                  rd_start;
    logic                  rd_stop;
    logic                  running;   // Set for the whole run, as a CPU would report it
    logic                  done;      // Result ready

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= IDLE;
            byte_cnt <= '0;
            timer    <= '0;
            passed   <= 1'b0;
            req_sent <= 1'b0;
            tx_start <= 1'b0;
            byte_req <= 1'b0;
            rd_start <= 1'b0;
            rd_stop  <= 1'b0;
            running  <= 1'b0;
            done     <= 1'b0;
        end else begin
            tx_start <= 1'b0;  // Pulses
            byte_req <= 1'b0;
            rd_start <= 1'b0;
            rd_stop  <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_run) begin
                        rd_start <= 1'b1;  // Open the flash read
                        passed   <= 1'b1;
                        running  <= 1'b1;
                        byte_cnt <= '0;
                        req_sent <= 1'b0;
                        state    <= FETCH;
                    end
                end
                FETCH: begin
                    if (fr.rd_valid) begin
                        tx_byte  <= fr.rd_data;
                        req_sent <= 1'b0;
                        state    <= SEND;
                    end else if (fr.ready && !req_sent) begin
                        byte_req <= 1'b1;
                        req_sent <= 1'b1;
                    end
                end
                SEND: begin
                    if (!ser.tx_busy) begin  // Only back-pressure point
                        tx_start <= 1'b1;
                        timer    <= '0;
                        state    <= WAIT_ECHO;
                    end
                end
                WAIT_ECHO: begin
                    timer <= timer + 1'b1;
                    if (ser.rx_valid || timer == ECHO_W'(ECHO_TIMEOUT - 1)) begin
                        if (!ser.rx_valid || ser.rx_data != tx_byte) begin
                            passed <= 1'b0;  // Timeout or mismatch
                        end
                        if (byte_cnt == BYTE_CNT_W'(TEST_BYTES - 1)) begin
                            rd_stop <= 1'b1;  // Release the flash
                            running <= 1'b0;
                            done    <= 1'b1;
                            state   <= DONE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= FETCH;
                        end
                    end
                end
                DONE: state <= DONE;  // Held until reset
                default: state <= IDLE;
            endcase
        end
    end

    assign ser.tx_data  = tx_byte;
    assign ser.tx_start = tx_start;
    assign fr.start     = rd_start;
    assign fr.stop      = rd_stop;
    assign fr.byte_req  = byte_req;

    // Running and status flags straight onto the LED
    assign o_led_b = running;
    assign o_led_g = done && passed;
    assign o_led_r = done && !passed;

    // One colour at a time on the RGB LED
    a_one_led: assert property (
        @(posedge clk) disable iff (i_rst) $onehot0({o_led_r, o_led_g, o_led_b})
    );

endmodule

// File: hdl/selftest_top.sv
// Board self-test top level with start-up delay, UART, SPI flash reader and controller
`timescale 1ns/100ps

module selftest_top (
    input  logic clk,
    input  logic i_rst,
    input  logic i_rx,     // UART receive, looped back externally
    input  logic i_cipo,   // Flash data out
    output logic o_tx,     // UART transmit
    output logic o_cs,     // Flash chip select, active low
    output logic o_copi,   // Flash data in
    output logic o_sclk,
    output logic o_led_r,  // Fail
    output logic o_led_g,  // Pass
    output logic o_led_b   // Running
);

    logic run;  // Start-up delay over

    serial_if     ser ();
    flash_read_if fr ();

    power_on_delay u_delay (.clk(clk), .i_rst(i_rst), .o_run(run));

    uart_tx u_tx (.clk(clk), .i_rst(i_rst), .o_tx(o_tx), .ser(ser.tx));

    uart_rx u_rx (.clk(clk), .i_rst(i_rst), .i_rx(i_rx), .ser(ser.rx));

    spi_flash_reader u_flash (
        .clk    (clk),
        .i_rst  (i_rst),
        .o_cs   (o_cs),
        .o_sclk (o_sclk),
        .o_copi (o_copi),
        .i_cipo (i_cipo),
        .fr     (fr.reader)
    );

    selftest_ctrl u_ctrl (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_run   (run),
        .ser     (ser.ctrl),
        .fr      (fr.ctrl),
        .o_led_r (o_led_r),
        .o_led_g (o_led_g),
        .o_led_b (o_led_b)
    );

endmodule

// File: tb/clock_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/100ps

module clock_gen (
    output logic o_clk,
    output logic o_rst
);

    localparam time HALF_PERIOD = 50ns;  // 100 ns period
    localparam int  RST_CYCLES  = 3;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Reset held for the first few rising edges
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// File: tb/tb_selftest.sv
// Self-test testbench with flash model, UART loopback model, LFSR stimulus, checks and report
`timescale 1ns/100ps

module tb_selftest;

    localparam int          N_BYTES      = 8;             // Bytes per run
    localparam logic [31:0] EXP_CMD      = 32'h0300_0000;  // Read command, address 0
    localparam int          MIN_IDLE     = 64;            // Start-up delay
    localparam int          ECHO_MODE    = 0;
    localparam int          CORRUPT_MODE = 1;
    localparam int          SILENT_MODE  = 2;

    logic clk;
    logic gen_rst;
    logic tb_rst = 1'b0;   // Reset between runs
    logic dut_rst;
    logic i_rx   = 1'b1;   // Line idles high
    logic i_cipo = 1'b0;
    logic o_tx, o_cs, o_copi, o_sclk, o_led_r, o_led_g, o_led_b;

    logic [7:0]  image [0:255];  // Flash contents
    logic [15:0] lfsr;
    int          errors;
    int          tests;
    int          failed_tests;
    bit          aborted;
    int          mode;
    int          bad_k;           // Frame corrupted in the replay

    // Flash model state
    logic [31:0] cmd_word;
    int          rise_cnt = 0;
    int          idx;

    // Loopback model state
    logic        dec_busy;
    int          dec_cnt;
    logic [7:0]  dec_shift;
    logic [7:0]  frames [0:15];  // Bytes decoded from o_tx
    int          frame_cnt;
    logic        lb_flip;

    assign dut_rst = gen_rst | tb_rst;

    clock_gen u_clk (.o_clk(clk), .o_rst(gen_rst));

    selftest_top uut (
        .clk     (clk),
        .i_rst   (dut_rst),
        .i_rx    (i_rx),
        .i_cipo  (i_cipo),
        .o_tx    (o_tx),
        .o_cs    (o_cs),
        .o_copi  (o_copi),
        .o_sclk  (o_sclk),
        .o_led_r (o_led_r),
        .o_led_g (o_led_g),
        .o_led_b (o_led_b)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
        errors++;
    endtask

    // Flash model, command in on rising sclk, chip select high clears it
    always @(posedge o_sclk or posedge o_cs) begin
        if (o_cs) begin
            rise_cnt <= 0;
        end else begin
            if (rise_cnt < 32) begin
                cmd_word <= {cmd_word[30:0], o_copi};  // MSB first
            end
            rise_cnt <= rise_cnt + 1;
        end
    end

    // Data out on falling sclk, first bit right after the address
    always @(negedge o_sclk) begin
        if (!o_cs && rise_cnt >= 32) begin
            idx = rise_cnt - 32;                           // Data bits already taken
            i_cipo <= image[idx[10:3]][3'd7 - idx[2:0]];   // Base address 0
        end
    end

    // Data bits of the frame picked for corruption
    assign lb_flip = (mode == CORRUPT_MODE) && (frame_cnt == bad_k) && dec_busy
                     && (dec_cnt >= 8) && (dec_cnt < 72);

    // Loopback, decodes o_tx and replays it one cycle later
    always @(posedge clk) begin
        if (dut_rst) begin
            dec_busy  <= 1'b0;
            dec_cnt   <= 0;
            frame_cnt <= 0;
            i_rx      <= 1'b1;
        end else begin
            i_rx <= (mode == SILENT_MODE) ? 1'b1 : (o_tx ^ lb_flip);
            if (!dec_busy) begin
                if (o_tx == 1'b0) begin  // Start bit, cycle 0
                    dec_busy <= 1'b1;
                    dec_cnt  <= 1;
                end
            end else begin
                dec_cnt <= dec_cnt + 1;
                if (dec_cnt >= 12 && dec_cnt <= 68 && dec_cnt % 8 == 4) begin
                    dec_shift <= {o_tx, dec_shift[7:1]};  // Mid data bit, LSB first
                end
                if (dec_cnt == 76) begin  // Mid stop bit
                    dec_busy <= 1'b0;
                    if (frame_cnt < 16) begin
                        frames[frame_cnt] <= dec_shift;
                        frame_cnt         <= frame_cnt + 1;
                    end
                end
            end
        end
    end

    // One full run from reset to the LED result
    task automatic run_test(input int m, input string name);
        int         err0;
        int         n;
        bit         ok;
        bit         expect_pass;
        logic [7:0] k8;
        err0        = errors;
        expect_pass = (m == ECHO_MODE);
        mode        = m;
        bad_k       = -1;
        if (m == CORRUPT_MODE) begin
            take_bits(3, k8);
            bad_k = int'(k8[2:0]);
        end
        @(posedge clk);
        tb_rst <= 1'b1;
        repeat (3) @(posedge clk);
        tb_rst <= 1'b0;

        // Start-up, everything idle until blue shows the run has begun
        n  = 0;
        ok = 0;
        while (!ok && n < 200) begin
            @(negedge clk);
            if (o_led_b === 1'b1) begin
                ok = 1;
            end else begin
                n++;
                if (o_cs !== 1'b1) value_error("o_cs", 32'h1, {31'h0, o_cs});
                if (o_sclk !== 1'b0) value_error("o_sclk", 32'h0, {31'h0, o_sclk});
                if (o_tx !== 1'b1) value_error("o_tx", 32'h1, {31'h0, o_tx});
                if ({o_led_r, o_led_g} !== 2'b00)
                    value_error("leds", 32'h0, {29'h0, o_led_r, o_led_g, o_led_b});
            end
        end
        if (!ok) begin
            $display("Test %s: run never started after reset", name);
            aborted = 1;
            return;
        end
        if (n < MIN_IDLE) begin
            $display("Run started after only %0d start-up cycles", n);
            errors++;
        end

        // Flash selected shortly after the run starts
        n  = 0;
        ok = 0;
        while (!ok && n < 20) begin
            @(negedge clk);
            n++;
            if (o_cs === 1'b0) ok = 1;
        end
        if (!ok) begin
            $display("Test %s: chip select never fell after the run started", name);
            aborted = 1;
            return;
        end

        // Running, blue on and flash selected until a result shows
        n  = 0;
        ok = 0;
        while (!ok && n < 12000) begin
            @(negedge clk);
            n++;
            if (o_led_g === 1'b1 || o_led_r === 1'b1) begin
                ok = 1;
            end else begin
                if (o_led_b !== 1'b1) value_error("o_led_b", 32'h1, {31'h0, o_led_b});
                if (o_cs !== 1'b0) value_error("o_cs", 32'h0, {31'h0, o_cs});
            end
        end
        if (!ok) begin
            $display("Test %s: no result on the LEDs", name);
            aborted = 1;
            return;
        end
        if ({o_led_r, o_led_g, o_led_b} !== {!expect_pass, expect_pass, 1'b0})
            value_error("leds", {29'h0, !expect_pass, expect_pass, 1'b0},
                        {29'h0, o_led_r, o_led_g, o_led_b});

        // Frames sent, always the first image bytes in order
        if (frame_cnt != N_BYTES) begin
            $display("Expected %0d UART frames, decoded %0d", N_BYTES, frame_cnt);
            errors++;
        end
        for (int i = 0; i < N_BYTES; i++) begin
            if (frames[i] !== image[i])
                value_error($sformatf("o_tx frame %0d", i), {24'h0, image[i]},
                            {24'h0, frames[i]});
        end
        if (cmd_word !== EXP_CMD) value_error("o_copi command", EXP_CMD, cmd_word);

        // Flash released once the run is over
        n  = 0;
        ok = 0;
        while (!ok && n < 20) begin
            @(negedge clk);
            n++;
            if (o_cs === 1'b1) ok = 1;
        end
        if (!ok) begin
            $display("Chip select stayed low after the run ended");
            errors++;
        end

        tests++;
        if (errors == err0) begin
            $display("Test %s: ok", name);
        end else begin
            failed_tests++;
            $display("Test %s: %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        logic [7:0] b;
        int         n;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        aborted      = 0;
        mode         = ECHO_MODE;
        bad_k        = -1;
        lfsr         = 16'd27;  // Seed
        for (int a = 0; a < 256; a++) begin
            take_bits(8, b);
            image[a] = b;
        end
        n = 0;
        while (gen_rst !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (gen_rst !== 1'b0) begin
            $display("Power-on reset was never released");
            aborted = 1;
        end
        if (!aborted) run_test(ECHO_MODE, "echo");
        if (!aborted) run_test(CORRUPT_MODE, "corrupt echo");
        if (!aborted) run_test(SILENT_MODE, "missing echo");
        $display("Tests run %0d, failed %0d, errors %0d, aborted %0d",
                 tests, failed_tests, errors, aborted);
        if (aborted || errors != 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/selftest_pkg.sv
hdl/serial_if.sv
hdl/flash_read_if.sv
hdl/power_on_delay.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/spi_flash_reader.sv
hdl/selftest_ctrl.sv
hdl/selftest_top.sv
tb/clock_gen.sv
tb/tb_selftest.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the self-test simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_selftest -f build.f -o sim_selftest
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_selftest)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
    exit 0
fi
exit 1
